// File: logic/event_pkg.sv
package event_pkg;

    // link and output stream widths
    localparam int NUM_LINKS  = 4;
    localparam int LINK_IDX_W = $clog2(NUM_LINKS);
    localparam int LINK_W     = 32;
    localparam int QWORD_W    = 64;

    // per-link quadword buffer
    localparam int FIFO_DEPTH = 16;
    localparam int FIFO_AW    = 4;

    // register port
    localparam int APB_AW = 8;
    localparam int APB_DW = 32;

    // top 16 bits of every header quadword
    localparam logic [15:0] HDR_MAGIC = 16'hE7B1;

    // one bit per link, set means the link is masked off
    typedef logic [NUM_LINKS-1:0] link_mask_t;

    // register offsets
    // CTRL holds event_open in bit 0 and the link mask in bits 7:4
    typedef enum logic [APB_AW-1:0] {
        REG_CTRL     = 8'h00,
        REG_EV_COUNT = 8'h04,
        REG_QW_COUNT = 8'h08
    } reg_addr_e;

    // readout FSM
    typedef enum logic [1:0] {
        RD_IDLE,
        RD_HEADER,
        RD_LINK,
        RD_NEXT
    } readout_state_e;

endpackage

// File: logic/event_ifs.sv
`timescale 1ns/1ns

// 32-bit words from one readout link
interface link_word_if;

    logic [event_pkg::LINK_W-1:0] tdata;
    logic                         tvalid;
    logic                         tready;
    logic                         tlast;

    modport src (
        output tdata,
        output tvalid,
        output tlast,
        input  tready
    );

    modport dst (
        input  tdata,
        input  tvalid,
        input  tlast,
        output tready
    );

endinterface

// packed quadwords from one link buffer
interface qword_if;

    logic [event_pkg::QWORD_W-1:0] tdata;
    logic                          tvalid;
    logic                          tready;
    logic                          tlast;

    modport src (
        output tdata,
        output tvalid,
        output tlast,
        input  tready
    );

    modport dst (
        input  tdata,
        input  tvalid,
        input  tlast,
        output tready
    );

endinterface

// File: logic/event_regs_apb.sv
`timescale 1ns/1ns

module event_regs_apb (
    input  logic                            aclk,
    input  logic                            arst_n_i,
    input  logic [event_pkg::APB_AW-1:0]    paddr_i,
    input  logic                            psel_i,
    input  logic                            penable_i,
    input  logic                            pwrite_i,
    input  logic [event_pkg::APB_DW-1:0]    pwdata_i,
    output logic [event_pkg::APB_DW-1:0]    prdata_o,
    output logic                            pready_o,
    output logic                            pslverr_o,
    output logic                            event_open_o,
    output event_pkg::link_mask_t           link_mask_o,
    input  logic                            ev_done_i,
    input  logic                            qw_done_i
);

    logic                         access;
    logic                         addr_known;
    logic                         addr_ro;
    logic                         event_open_q;
    event_pkg::link_mask_t        link_mask_q;
    logic [event_pkg::APB_DW-1:0] ev_count_q;
    logic [event_pkg::APB_DW-1:0] qw_count_q;

    // zero wait states, the access phase always completes
    assign access   = psel_i && penable_i;
    assign pready_o = 1'b1;

    always_comb begin
        addr_known = 1'b1;
        addr_ro    = 1'b0;
        prdata_o   = '0;
        case (paddr_i)
            event_pkg::REG_CTRL: begin
                prdata_o = event_pkg::APB_DW'({link_mask_q, 3'b000, event_open_q});
            end
            event_pkg::REG_EV_COUNT: begin
                prdata_o = ev_count_q;
                addr_ro  = 1'b1;
            end
            event_pkg::REG_QW_COUNT: begin
                prdata_o = qw_count_q;
                addr_ro  = 1'b1;
            end
            default: addr_known = 1'b0;
        endcase
    end

    assign pslverr_o = access && (!addr_known || (pwrite_i && addr_ro));

    always_ff @(posedge aclk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            event_open_q <= 1'b0;
            link_mask_q  <= '0;
            ev_count_q   <= '0;
            qw_count_q   <= '0;
        end else begin
            if (access && pwrite_i && paddr_i == event_pkg::REG_CTRL) begin
                event_open_q <= pwdata_i[0];
                link_mask_q  <= pwdata_i[7:4];
            end
            if (ev_done_i)
                ev_count_q <= ev_count_q + 1'b1;
            // headers count as quadwords too
            if (qw_done_i)
                qw_count_q <= qw_count_q + 1'b1;
        end
    end

    assign event_open_o = event_open_q;
    assign link_mask_o  = link_mask_q;

endmodule

// File: logic/event_completion_tracker.sv
`timescale 1ns/1ns

module event_completion_tracker (
    input  logic                                                  aclk,
    input  logic                                                  arst_n_i,
    input  logic [event_pkg::NUM_LINKS-1:0][event_pkg::LINK_W-1:0] link_tdata_i,
    input  logic [event_pkg::NUM_LINKS-1:0]                       link_tvalid_i,
    input  logic [event_pkg::NUM_LINKS-1:0]                       link_tlast_i,
    output logic [event_pkg::NUM_LINKS-1:0]                       link_tready_o,
    input  logic                                                  event_open_i,
    input  event_pkg::link_mask_t                                 link_mask_i,
    link_word_if.src                                              link_o [event_pkg::NUM_LINKS],
    output logic                                                  complete_o,
    input  logic                                                  start_i
);

    event_pkg::link_mask_t seen_q;
    event_pkg::link_mask_t last_xfer;

    for (genvar g = 0; g < event_pkg::NUM_LINKS; g++) begin : g_link
        logic active;

        assign active = event_open_i && !link_mask_i[g];

        // data passes straight through, only the handshake is gated
        assign link_o[g].tdata  = link_tdata_i[g];
        assign link_o[g].tlast  = link_tlast_i[g];
        assign link_o[g].tvalid = link_tvalid_i[g] && active && !seen_q[g];

        // closed or masked links swallow their words
        assign link_tready_o[g] = active ? (link_o[g].tready && !seen_q[g]) : 1'b1;

        assign last_xfer[g] = link_o[g].tvalid && link_o[g].tready && link_tlast_i[g];
    end

    // a link that has finished is held off until the readout takes the event
    always_ff @(posedge aclk or negedge arst_n_i) begin
        if (!arst_n_i)
            seen_q <= '0;
        else
            seen_q <= (seen_q & ~{event_pkg::NUM_LINKS{start_i}}) | last_xfer;
    end

    // all links masked means there is never anything to build
    assign complete_o = (&(seen_q | link_mask_i)) && !(&link_mask_i);

endmodule

// File: logic/link_accumulator.sv
`timescale 1ns/1ns

module link_accumulator (
    input  logic     aclk,
    input  logic     arst_n_i,
    link_word_if.dst link_i,
    qword_if.src     qword_o
);

    // each entry is the quadword with its tlast bit on top
    logic [event_pkg::QWORD_W:0]   mem [event_pkg::FIFO_DEPTH];
    logic [event_pkg::FIFO_AW-1:0] wr_ptr_q;
    logic [event_pkg::FIFO_AW-1:0] rd_ptr_q;
    logic [event_pkg::FIFO_AW:0]   count_q;
    logic [event_pkg::LINK_W-1:0]  half_q;
    logic                          half_vld_q;
    logic                          full;
    logic                          word_xfer;
    logic                          push;
    logic                          pop;
    logic [event_pkg::QWORD_W:0]   push_entry;

    assign full          = count_q == (event_pkg::FIFO_AW + 1)'(event_pkg::FIFO_DEPTH);
    assign link_i.tready = !full;
    assign word_xfer     = link_i.tvalid && link_i.tready;

    // a quadword is complete on the second word of a pair or on a lone last word
    assign push = word_xfer && (half_vld_q || link_i.tlast);

    always_comb begin
        if (half_vld_q)
            push_entry = {link_i.tlast, link_i.tdata, half_q};
        else
            push_entry = {link_i.tlast, {event_pkg::LINK_W{1'b0}}, link_i.tdata};
    end

    always_ff @(posedge aclk or negedge arst_n_i) begin
        if (!arst_n_i)
            half_vld_q <= 1'b0;
        else if (word_xfer)
            half_vld_q <= !half_vld_q && !link_i.tlast;
    end

    // low half waits here for its partner
    always_ff @(posedge aclk) begin
        if (word_xfer && !half_vld_q)
            half_q <= link_i.tdata;
    end

    always_ff @(posedge aclk) begin
        if (push)
            mem[wr_ptr_q] <= push_entry;
    end

    assign qword_o.tdata  = mem[rd_ptr_q][event_pkg::QWORD_W-1:0];
    assign qword_o.tlast  = mem[rd_ptr_q][event_pkg::QWORD_W];
    assign qword_o.tvalid = count_q != '0;
    assign pop            = qword_o.tvalid && qword_o.tready;

    // pointers wrap on their own since the depth is a power of two
    always_ff @(posedge aclk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push)
                wr_ptr_q <= wr_ptr_q + 1'b1;
            if (pop)
                rd_ptr_q <= rd_ptr_q + 1'b1;
            if (push && !pop)
                count_q <= count_q + 1'b1;
            else if (pop && !push)
                count_q <= count_q - 1'b1;
        end
    end

endmodule

// File: logic/event_readout.sv
`timescale 1ns/1ns

module event_readout (
    input  logic                          aclk,
    input  logic                          arst_n_i,
    qword_if.dst                          link_i [event_pkg::NUM_LINKS],
    input  event_pkg::link_mask_t         link_mask_i,
    input  logic                          complete_i,
    output logic                          start_o,
    output logic [event_pkg::QWORD_W-1:0] ev_tdata_o,
    output logic                          ev_tvalid_o,
    output logic                          ev_tlast_o,
    input  logic                          ev_tready_i,
    output logic                          ev_done_o,
    output logic                          qw_done_o
);

    event_pkg::readout_state_e                              state_q;
    logic [event_pkg::LINK_IDX_W-1:0]                       cur_q;
    logic [event_pkg::LINK_IDX_W-1:0]                       first_link;
    logic [event_pkg::LINK_IDX_W-1:0]                       out_link;
    event_pkg::link_mask_t                                  todo_q;
    event_pkg::link_mask_t                                  mask_q;
    logic [31:0]                                            ev_num_q;
    logic [event_pkg::NUM_LINKS-1:0][event_pkg::QWORD_W-1:0] q_data;
    event_pkg::link_mask_t                                  q_valid;
    event_pkg::link_mask_t                                  q_last;
    logic                                                   in_link;
    logic                                                   is_last;
    logic                                                   ev_xfer;
    logic [event_pkg::QWORD_W-1:0]                          header;

    // lowest link still waiting to be read out
    always_comb begin
        first_link = '0;
        for (int i = event_pkg::NUM_LINKS - 1; i >= 0; i--) begin
            if (todo_q[i])
                first_link = event_pkg::LINK_IDX_W'(i);
        end
    end

    // RD_NEXT forwards the first quadword of the new link directly
    assign in_link  = state_q == event_pkg::RD_LINK || state_q == event_pkg::RD_NEXT;
    assign out_link = (state_q == event_pkg::RD_NEXT) ? first_link : cur_q;
    assign is_last  = (state_q == event_pkg::RD_NEXT) ?
                      (todo_q & ~(event_pkg::link_mask_t'(1) << first_link)) == '0 :
                      todo_q == '0;

    for (genvar g = 0; g < event_pkg::NUM_LINKS; g++) begin : g_link
        assign q_data[g]       = link_i[g].tdata;
        assign q_valid[g]      = link_i[g].tvalid;
        assign q_last[g]       = link_i[g].tlast;
        assign link_i[g].tready = in_link && ev_tready_i &&
                                  out_link == event_pkg::LINK_IDX_W'(g);
    end

    assign header = {event_pkg::HDR_MAGIC, mask_q, 12'h000, ev_num_q};

    always_comb begin
        ev_tdata_o  = header;
        ev_tvalid_o = 1'b0;
        ev_tlast_o  = 1'b0;
        if (state_q == event_pkg::RD_HEADER) begin
            ev_tvalid_o = 1'b1;
        end else if (in_link) begin
            ev_tdata_o  = q_data[out_link];
            ev_tvalid_o = q_valid[out_link];
            ev_tlast_o  = q_last[out_link] && is_last;
        end
    end

    assign ev_xfer   = ev_tvalid_o && ev_tready_i;
    assign qw_done_o = ev_xfer;
    assign ev_done_o = ev_xfer && ev_tlast_o;
    assign start_o   = state_q == event_pkg::RD_IDLE && complete_i;

    always_ff @(posedge aclk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q <= event_pkg::RD_IDLE;
            cur_q   <= '0;
            todo_q  <= '0;
            mask_q  <= '0;
        end else begin
            case (state_q)
                event_pkg::RD_IDLE: begin
                    if (start_o) begin
                        mask_q  <= link_mask_i;
                        todo_q  <= ~link_mask_i;
                        state_q <= event_pkg::RD_HEADER;
                    end
                end
                event_pkg::RD_HEADER: begin
                    if (ev_xfer)
                        state_q <= event_pkg::RD_NEXT;
                end
                event_pkg::RD_NEXT: begin
                    if (ev_xfer) begin
                        cur_q              <= first_link;
                        todo_q[first_link] <= 1'b0;
                        if (!q_last[first_link])
                            state_q <= event_pkg::RD_LINK;
                        else if (is_last)
                            state_q <= event_pkg::RD_IDLE;
                    end
                end
                event_pkg::RD_LINK: begin
                    if (ev_xfer && q_last[cur_q])
                        state_q <= is_last ? event_pkg::RD_IDLE : event_pkg::RD_NEXT;
                end
                default: state_q <= event_pkg::RD_IDLE;
            endcase
        end
    end

    // event number goes into the next header
    always_ff @(posedge aclk or negedge arst_n_i) begin
        if (!arst_n_i)
            ev_num_q <= '0;
        else if (ev_done_o)
            ev_num_q <= ev_num_q + 1'b1;
    end

endmodule

// File: logic/event_builder_top.sv
`timescale 1ns/1ns

module event_builder_top (
    input  logic                                                  aclk,
    input  logic                                                  arst_n_i,
    input  logic [event_pkg::NUM_LINKS-1:0][event_pkg::LINK_W-1:0] link_tdata_i,
    input  logic [event_pkg::NUM_LINKS-1:0]                       link_tvalid_i,
    input  logic [event_pkg::NUM_LINKS-1:0]                       link_tlast_i,
    output logic [event_pkg::NUM_LINKS-1:0]                       link_tready_o,
    output logic [event_pkg::QWORD_W-1:0]                         ev_tdata_o,
    output logic                                                  ev_tvalid_o,
    output logic                                                  ev_tlast_o,
    input  logic                                                  ev_tready_i,
    input  logic [event_pkg::APB_AW-1:0]                          paddr_i,
    input  logic                                                  psel_i,
    input  logic                                                  penable_i,
    input  logic                                                  pwrite_i,
    input  logic [event_pkg::APB_DW-1:0]                          pwdata_i,
    output logic [event_pkg::APB_DW-1:0]                          prdata_o,
    output logic                                                  pready_o,
    output logic                                                  pslverr_o
);

    logic                  event_open;
    event_pkg::link_mask_t link_mask;
    logic                  complete;
    logic                  start;
    logic                  ev_done;
    logic                  qw_done;

    // gated link words into the accumulators, packed quadwords out
    link_word_if link_w [event_pkg::NUM_LINKS] ();
    qword_if     link_qw [event_pkg::NUM_LINKS] ();

    event_regs_apb i_regs (
        .aclk         (aclk),
        .arst_n_i     (arst_n_i),
        .paddr_i      (paddr_i),
        .psel_i       (psel_i),
        .penable_i    (penable_i),
        .pwrite_i     (pwrite_i),
        .pwdata_i     (pwdata_i),
        .prdata_o     (prdata_o),
        .pready_o     (pready_o),
        .pslverr_o    (pslverr_o),
        .event_open_o (event_open),
        .link_mask_o  (link_mask),
        .ev_done_i    (ev_done),
        .qw_done_i    (qw_done)
    );

    event_completion_tracker i_tracker (
        .aclk          (aclk),
        .arst_n_i      (arst_n_i),
        .link_tdata_i  (link_tdata_i),
        .link_tvalid_i (link_tvalid_i),
        .link_tlast_i  (link_tlast_i),
        .link_tready_o (link_tready_o),
        .event_open_i  (event_open),
        .link_mask_i   (link_mask),
        .link_o        (link_w),
        .complete_o    (complete),
        .start_i       (start)
    );

    for (genvar g = 0; g < event_pkg::NUM_LINKS; g++) begin : g_acc
        link_accumulator i_acc (
            .aclk     (aclk),
            .arst_n_i (arst_n_i),
            .link_i   (link_w[g]),
            .qword_o  (link_qw[g])
        );
    end

    event_readout i_readout (
        .aclk        (aclk),
        .arst_n_i    (arst_n_i),
        .link_i      (link_qw),
        .link_mask_i (link_mask),
        .complete_i  (complete),
        .start_o     (start),
        .ev_tdata_o  (ev_tdata_o),
        .ev_tvalid_o (ev_tvalid_o),
        .ev_tlast_o  (ev_tlast_o),
        .ev_tready_i (ev_tready_i),
        .ev_done_o   (ev_done),
        .qw_done_o   (qw_done)
    );

endmodule

// File: sim/event_builder_chk.sv
`timescale 1ns/1ns

module event_builder_chk (
    input logic                          aclk,
    input logic                          arst_n_i,
    input logic [event_pkg::QWORD_W-1:0] ev_tdata,
    input logic                          ev_tvalid,
    input logic                          ev_tlast,
    input logic                          ev_tready,
    input logic                          pready
);

    // a stalled quadword stays on the bus unchanged
    stall_hold: assert property (@(posedge aclk) disable iff (!arst_n_i)
        ev_tvalid && !ev_tready |=> ev_tvalid && $stable(ev_tdata) && $stable(ev_tlast))
        else $error("output quadword changed or dropped while stalled");

    reset_quiet: assert property (@(posedge aclk) !arst_n_i |-> !ev_tvalid)
        else $error("output valid high during reset");

    // zero wait state register port
    apb_ready: assert property (@(posedge aclk) disable iff (!arst_n_i) pready)
        else $error("APB pready went low");

endmodule

bind event_builder_top event_builder_chk i_chk (
    .aclk      (aclk),
    .arst_n_i  (arst_n_i),
    .ev_tdata  (ev_tdata_o),
    .ev_tvalid (ev_tvalid_o),
    .ev_tlast  (ev_tlast_o),
    .ev_tready (ev_tready_i),
    .pready    (pready_o)
);

// File: sim/tb_event_builder.sv
`timescale 1ns/1ns

module tb_event_builder;

    localparam int CLK_PERIOD      = 4;
    localparam int RST_CYCLES      = 16;
    localparam int CYCLES_PER_TEST = 200;
    localparam int IDLE_CYCLES     = 20;
    localparam int MAX_TESTS       = 16;

    logic                                                  aclk = 1'b0;
    logic                                                  arst_n_i;
    logic [event_pkg::NUM_LINKS-1:0][event_pkg::LINK_W-1:0] link_tdata;
    logic [event_pkg::NUM_LINKS-1:0]                       link_tvalid;
    logic [event_pkg::NUM_LINKS-1:0]                       link_tlast;
    logic [event_pkg::NUM_LINKS-1:0]                       link_tready;
    logic [event_pkg::QWORD_W-1:0]                         ev_tdata;
    logic                                                  ev_tvalid;
    logic                                                  ev_tlast;
    logic                                                  ev_tready = 1'b1;
    logic [event_pkg::APB_AW-1:0]                          paddr;
    logic                                                  psel;
    logic                                                  penable;
    logic                                                  pwrite;
    logic [event_pkg::APB_DW-1:0]                          pwdata;
    logic [event_pkg::APB_DW-1:0]                          prdata;
    logic                                                  pready;
    logic                                                  pslverr;

    // golden table
    string                 t_name  [MAX_TESTS];
    event_pkg::link_mask_t t_mask  [MAX_TESTS];
    logic                  t_open  [MAX_TESTS];
    logic                  t_stall [MAX_TESTS];
    int                    t_cnt   [MAX_TESTS][event_pkg::NUM_LINKS];
    int                    t_qw    [MAX_TESTS];
    logic [63:0]           t_xor   [MAX_TESTS];
    int                    n_tests;
    bit                    golden_loaded = 1'b0;

    // output monitor state for the running test
    string       cur_name;
    int          cur_exp_qw;
    logic [63:0] exp_hdr;
    logic [31:0] ev_num_exp;
    int          mon_qw;
    logic [63:0] mon_xor;
    bit          mon_end;
    logic        stall_mode;
    int          errors;
    int          n_run;
    int          n_failed;

    event_builder_top i_event_builder_top (
        .aclk          (aclk),
        .arst_n_i      (arst_n_i),
        .link_tdata_i  (link_tdata),
        .link_tvalid_i (link_tvalid),
        .link_tlast_i  (link_tlast),
        .link_tready_o (link_tready),
        .ev_tdata_o    (ev_tdata),
        .ev_tvalid_o   (ev_tvalid),
        .ev_tlast_o    (ev_tlast),
        .ev_tready_i   (ev_tready),
        .paddr_i       (paddr),
        .psel_i        (psel),
        .penable_i     (penable),
        .pwrite_i      (pwrite),
        .pwdata_i      (pwdata),
        .prdata_o      (prdata),
        .pready_o      (pready),
        .pslverr_o     (pslverr)
    );

    always #(CLK_PERIOD / 2) aclk = ~aclk;

    // output ready toggles randomly while a back-pressure test runs
    always @(posedge aclk) begin
        #1;
        ev_tready = stall_mode ? (($urandom % 2) != 0) : 1'b1;
    end

    // transfers are sampled on the falling edge where all outputs have settled
    always @(negedge aclk) begin
        if (arst_n_i && ev_tvalid && ev_tready) begin
            if (mon_qw == 0) begin
                check_value(cur_name, "header", exp_hdr, ev_tdata);
            end
            check_value(cur_name, "tlast", 64'(mon_qw == cur_exp_qw - 1), 64'(ev_tlast));
            mon_xor = mon_xor ^ ev_tdata;
            mon_qw++;
            if (ev_tlast)
                mon_end = 1'b1;
        end
    end

    task automatic check_value(input string test, input string what,
                               input logic [63:0] exp, input logic [63:0] act);
        assert (exp == act) else begin
            $display("Fail %0s %0s: expected %0h, actual %0h", test, what, exp, act);
            errors++;
        end
    endtask

    task automatic report_test(input string name, input int errs_before);
        n_run++;
        if (errors == errs_before) begin
            $display("test %0s: ok", name);
        end else begin
            n_failed++;
            $display("test %0s: %0d check(s) failed", name, errors - errs_before);
        end
    endtask

    task automatic load_golden();
        int                    fd;
        int                    r;
        string                 line;
        string                 nm;
        event_pkg::link_mask_t m;
        int                    op;
        int                    st;
        int                    c [event_pkg::NUM_LINKS];
        int                    qw;
        logic [63:0]           x;
        n_tests = 0;
        fd = $fopen("sim/event_golden.txt", "r");
        if (fd == 0) begin
            $display("cannot open sim/event_golden.txt");
            errors++;
        end else begin
            while (!$feof(fd) && n_tests < MAX_TESTS) begin
                r = $fgets(line, fd);
                if (r > 0 && line.getc(0) != "#") begin
                    r = $sscanf(line, "%s %h %d %d %d %d %d %d %d %h",
                                nm, m, op, st, c[0], c[1], c[2], c[3], qw, x);
                    if (r == 10) begin
                        t_name[n_tests]  = nm;
                        t_mask[n_tests]  = m;
                        t_open[n_tests]  = op != 0;
                        t_stall[n_tests] = st != 0;
                        for (int i = 0; i < event_pkg::NUM_LINKS; i++)
                            t_cnt[n_tests][i] = c[i];
                        t_qw[n_tests]  = qw;
                        t_xor[n_tests] = x;
                        n_tests++;
                    end
                end
            end
            $fclose(fd);
            if (n_tests == 0) begin
                $display("golden file holds no test lines");
                errors++;
            end
        end
        golden_loaded = 1'b1;
    endtask

    // one APB transfer that starts and ends 1 ns after a rising edge
    task automatic apb_access(input logic wr, input logic [7:0] addr, input logic [31:0] wdata,
                              output logic [31:0] rdata, output logic err);
        paddr   = addr;
        pwrite  = wr;
        pwdata  = wdata;
        psel    = 1'b1;
        penable = 1'b0;
        @(posedge aclk);
        #1;
        penable = 1'b1;
        @(negedge aclk);
        rdata = prdata;
        err   = pslverr;
        @(posedge aclk);
        #1;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    // word k of link n carries n in the top byte and k below
    task automatic drive_link(input int n, input int cnt, input logic stall,
                              input logic active);
        logic acc;
        for (int k = 0; k < cnt; k++) begin
            while (stall && ($urandom % 2 == 0)) begin
                @(posedge aclk);
                #1;
            end
            link_tdata[n]  = {n[7:0], k[23:0]};
            link_tvalid[n] = 1'b1;
            link_tlast[n]  = (k == cnt - 1);
            acc = 1'b0;
            while (!acc) begin
                @(negedge aclk);
                acc = link_tready[n];
                // closed or masked links never push back
                if (!active)
                    check_value(cur_name, $sformatf("link %0d ready", n), 64'(1), 64'(acc));
                @(posedge aclk);
                #1;
            end
            link_tvalid[n] = 1'b0;
            link_tlast[n]  = 1'b0;
        end
        // a finished link is held off until the readout takes the event
        if (active && cnt > 0) begin
            @(negedge aclk);
            check_value(cur_name, $sformatf("link %0d ready after last", n),
                        64'(0), 64'(link_tready[n]));
        end
    endtask

    task automatic run_reg_test();
        logic [31:0] rd;
        logic        err;
        int          errs_before;
        errs_before = errors;
        apb_access(1'b1, event_pkg::REG_CTRL, 32'h51, rd, err);
        check_value("regs", "CTRL write pslverr", 64'(0), 64'(err));
        apb_access(1'b0, event_pkg::REG_CTRL, '0, rd, err);
        check_value("regs", "CTRL readback", 64'h51, 64'(rd));
        apb_access(1'b1, event_pkg::REG_EV_COUNT, 32'h5, rd, err);
        check_value("regs", "EV_COUNT write pslverr", 64'(1), 64'(err));
        apb_access(1'b0, 8'h0C, '0, rd, err);
        check_value("regs", "unknown address pslverr", 64'(1), 64'(err));
        apb_access(1'b1, event_pkg::REG_CTRL, '0, rd, err);
        report_test("regs", errs_before);
    endtask

    task automatic run_event_test(input int t);
        logic [31:0] rd;
        logic [31:0] ev_before;
        logic        err;
        int          errs_before;
        errs_before = errors;
        cur_name    = t_name[t];
        cur_exp_qw  = t_qw[t];
        exp_hdr     = {event_pkg::HDR_MAGIC, t_mask[t], 12'h000, ev_num_exp};
        mon_qw      = 0;
        mon_xor     = '0;
        mon_end     = 1'b0;
        apb_access(1'b1, event_pkg::REG_CTRL, {24'h0, t_mask[t], 3'b000, t_open[t]}, rd, err);
        apb_access(1'b0, event_pkg::REG_EV_COUNT, '0, ev_before, err);
        stall_mode = t_stall[t];
        fork
            drive_link(0, t_cnt[t][0], t_stall[t], t_open[t] && !t_mask[t][0]);
            drive_link(1, t_cnt[t][1], t_stall[t], t_open[t] && !t_mask[t][1]);
            drive_link(2, t_cnt[t][2], t_stall[t], t_open[t] && !t_mask[t][2]);
            drive_link(3, t_cnt[t][3], t_stall[t], t_open[t] && !t_mask[t][3]);
        join
        if (t_qw[t] != 0)
            wait (mon_end);
        else
            repeat (IDLE_CYCLES) @(posedge aclk);
        @(posedge aclk);
        #1;
        stall_mode = 1'b0;
        check_value(t_name[t], "quadword count", 64'(t_qw[t]), 64'(mon_qw));
        check_value(t_name[t], "xor", t_xor[t], mon_xor);
        if (t_qw[t] == 0) begin
            apb_access(1'b0, event_pkg::REG_EV_COUNT, '0, rd, err);
            check_value(t_name[t], "REG_EV_COUNT", 64'(ev_before), 64'(rd));
        end else begin
            ev_num_exp++;
        end
        report_test(t_name[t], errs_before);
    endtask

    task automatic run_counter_test();
        logic [31:0] rd;
        logic        err;
        int          errs_before;
        int          ev_sum;
        int          qw_sum;
        errs_before = errors;
        ev_sum      = 0;
        qw_sum      = 0;
        for (int t = 0; t < n_tests; t++) begin
            qw_sum += t_qw[t];
            if (t_qw[t] != 0)
                ev_sum++;
        end
        apb_access(1'b0, event_pkg::REG_EV_COUNT, '0, rd, err);
        check_value("counters", "REG_EV_COUNT", 64'(ev_sum), 64'(rd));
        apb_access(1'b0, event_pkg::REG_QW_COUNT, '0, rd, err);
        check_value("counters", "REG_QW_COUNT", 64'(qw_sum), 64'(rd));
        report_test("counters", errs_before);
    endtask

    initial begin
        void'($urandom(30));
        arst_n_i    = 1'b0;
        link_tdata  = '0;
        link_tvalid = '0;
        link_tlast  = '0;
        paddr       = '0;
        psel        = 1'b0;
        penable     = 1'b0;
        pwrite      = 1'b0;
        pwdata      = '0;
        stall_mode  = 1'b0;
        errors      = 0;
        n_run       = 0;
        n_failed    = 0;
        ev_num_exp  = '0;
        mon_qw      = 0;
        mon_xor     = '0;
        mon_end     = 1'b0;
        cur_exp_qw  = 0;
        exp_hdr     = '0;
        cur_name    = "reset";
        load_golden();
        repeat (RST_CYCLES) @(posedge aclk);
        #1;
        arst_n_i = 1'b1;
        run_reg_test();
        for (int t = 0; t < n_tests; t++)
            run_event_test(t);
        run_counter_test();
        $display("summary: %0d tests run, %0d failed, %0d checks failed",
                 n_run, n_failed, errors);
        if (errors == 0)
            $display("TESTBENCH PASSED");
        else
            $display("TESTBENCH FAILED");
        $finish;
    end

    // budget scales with the number of golden lines
    initial begin
        wait (golden_loaded);
        #((n_tests * CYCLES_PER_TEST + RST_CYCLES) * CLK_PERIOD);
        $display("watchdog expired, a handshake or event never completed");
        $display("TESTBENCH FAILED");
        $finish;
    end

endmodule

// File: sim/event_golden.txt
# name mask open stall words_link0 words_link1 words_link2 words_link3 qwords xor
# mask and xor in hex, all other columns in decimal; qwords and xor include the header
full_event   0 1 0  5  6  1  4 10 e6b1000703000002
masked_link  4 1 0  3  2  7  4  6 e6b1400201000001
closed       0 0 0  3  3  3  3  0 0000000000000000
backpressure 0 1 1  5  6  1  4 10 e6b1000703000000
fifo_fill    1 1 1  9 32 31  2 34 e6b1101e03000003

// File: sources.f
logic/event_pkg.sv
logic/event_ifs.sv
logic/event_regs_apb.sv
logic/event_completion_tracker.sv
logic/link_accumulator.sv
logic/event_readout.sv
logic/event_builder_top.sv
sim/event_builder_chk.sv
sim/tb_event_builder.sv

// File: run_sim.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_event_builder -f sources.f -o tb_event_builder

out=$(./obj_dir/tb_event_builder)
echo "$out"
echo "$out" | grep -q "TESTBENCH PASSED"
